// ==== verilog/lsu_ctl_config.svh ====
// Build-time configuration of the LSU control pipeline.
// Include this header in any file that needs the thread count or the
// region tags of the memory map.

`ifndef LSU_CTL_CONFIG_SVH
`define LSU_CTL_CONFIG_SVH

// ******************************
// Threads
// ******************************
`define LSU_NUM_THREADS 2        // Sets flush vector and lr_vld widths

// ******************************
// Memory map region tags
// ******************************
`define LSU_REGION_MSB  31       // Tag sits at the top of the address
`define LSU_TAG_W       16       // Address bits 31:16

`define LSU_DCCM_TAG    16'hF004 // Local data memory
`define LSU_PIC_TAG     16'hF00C // Interrupt controller
// Anything else goes to the external bus

`endif

// ==== verilog/lsu_ctl_pkg.sv ====
// Types shared by the LSU control pipeline.
// Modules import this package in their body and use scoped names in ports.

`default_nettype none

`include "lsu_ctl_config.svh"

package lsu_ctl_pkg;

   // Thread id is at least one bit wide
   localparam int LSU_TID_W = (`LSU_NUM_THREADS > 1) ? $clog2(`LSU_NUM_THREADS) : 1;

   typedef logic [LSU_TID_W-1:0] lsu_tid_t;

   typedef enum logic [1:0] {
      OP_LOAD  = 2'd0,
      OP_STORE = 2'd1,
      OP_LR    = 2'd2,   // Load reserved
      OP_SC    = 2'd3    // Store conditional
   } lsu_op_e;

   typedef enum logic [1:0] {
      SZ_BYTE = 2'd0,
      SZ_HALF = 2'd1,
      SZ_WORD = 2'd2
   } lsu_size_e;

   typedef enum logic [1:0] {
      RG_DCCM = 2'd0,
      RG_PIC  = 2'd1,
      RG_EXT  = 2'd2
   } lsu_region_e;

   // Control packet carried down the pipe
   typedef struct packed {
      logic      valid;
      lsu_tid_t  tid;
      lsu_op_e   op;
      lsu_size_e size;
      logic      unsign;   // Zero-extend loads
   } lsu_pkt_t;

endpackage

`default_nettype wire

// ==== verilog/lsu_addr_gen.sv ====
// DC1 address generation for the LSU.
// Purely combinational on the DC1 registers; results are registered into
// DC2 by the packet pipe.

`timescale 1ns/100ps
`default_nettype none

`include "lsu_ctl_config.svh"

module lsu_addr_gen (
   input  logic [31:0]               rs1_dc1,      // Base register
   input  logic [11:0]               offset_dc1,   // Immediate offset
   input  lsu_ctl_pkg::lsu_size_e    size_dc1,
   output logic [31:0]               addr_dc1,
   output lsu_ctl_pkg::lsu_region_e  region_dc1,
   output logic                      misaligned_dc1
);

   import lsu_ctl_pkg::*;

   logic [31:0]            offset32_dc1;
   logic [`LSU_TAG_W-1:0]  region_tag_dc1;
   logic                   half_bad_dc1;
   logic                   word_bad_dc1;

   // ******************************
   // Effective address
   // ******************************
   assign offset32_dc1 = {{20{offset_dc1[11]}}, offset_dc1};
   assign addr_dc1     = rs1_dc1 + offset32_dc1;

   // ******************************
   // Region decode
   // ******************************
   assign region_tag_dc1 = addr_dc1[`LSU_REGION_MSB -: `LSU_TAG_W];

   always_comb begin
      if (region_tag_dc1 == `LSU_DCCM_TAG) begin
         region_dc1 = RG_DCCM;
      end else if (region_tag_dc1 == `LSU_PIC_TAG) begin
         region_dc1 = RG_PIC;
      end else begin
         region_dc1 = RG_EXT;   // Everything else is off-core
      end
   end

   // ******************************
   // Alignment check
   // ******************************
   // Bytes are always aligned
   assign half_bad_dc1   = (size_dc1 == SZ_HALF) & addr_dc1[0];
   assign word_bad_dc1   = (size_dc1 == SZ_WORD) & (|addr_dc1[1:0]);
   assign misaligned_dc1 = half_bad_dc1 | word_bad_dc1;

endmodule

`default_nettype wire

// ==== verilog/lsu_pkt_pipe.sv ====
// Stage registers for the LSU control pipeline, DC1 through DC5.
// Holds packet, address, region and store data, and applies the per-thread
// flush to the valid bit as a packet moves from one stage to the next.

`timescale 1ns/100ps
`default_nettype none

`include "lsu_ctl_config.svh"

module lsu_pkt_pipe (
   input  logic                          clk,
   input  logic                          rst_n,

   input  lsu_ctl_pkg::lsu_pkt_t         lsu_p,         // Packet from decode
   input  logic [31:0]                   rs1_d,
   input  logic [11:0]                   offset_d,
   input  logic [31:0]                   rs2_d,         // Store data

   input  logic [`LSU_NUM_THREADS-1:0]   flush_dc2_up,
   input  logic [`LSU_NUM_THREADS-1:0]   flush_dc3,
   input  logic [`LSU_NUM_THREADS-1:0]   flush_dc4,

   input  logic [31:0]                   addr_dc1,      // From address generation
   input  lsu_ctl_pkg::lsu_region_e      region_dc1,
   input  logic                          misaligned_dc1,

   output logic [31:0]                   rs1_dc1,
   output logic [11:0]                   offset_dc1,
   output lsu_ctl_pkg::lsu_pkt_t         pkt_dc1,

   output lsu_ctl_pkg::lsu_pkt_t         pkt_dc3,
   output logic [31:0]                   addr_dc3,
   output lsu_ctl_pkg::lsu_region_e      region_dc3,
   output logic                          misaligned_dc3,
   output logic [31:0]                   store_data_dc3,

   output lsu_ctl_pkg::lsu_pkt_t         pkt_dc5,
   output logic [31:0]                   addr_dc5
);

   import lsu_ctl_pkg::*;

   lsu_pkt_t     pkt_dc1_in, pkt_dc2_in, pkt_dc3_in, pkt_dc4_in, pkt_dc5_in;
   lsu_pkt_t     pkt_dc2, pkt_dc4;
   logic [31:0]  addr_dc2, addr_dc4;
   lsu_region_e  region_dc2;
   logic         misaligned_dc2;
   logic [31:0]  store_data_dc1, store_data_dc2;

   // ******************************
   // Flush qualification
   // ******************************
   always_comb begin
      pkt_dc1_in = lsu_p;
      pkt_dc2_in = pkt_dc1;
      pkt_dc3_in = pkt_dc2;
      pkt_dc4_in = pkt_dc3;
      pkt_dc5_in = pkt_dc4;

      // Only valid is killed, the rest rides along
      pkt_dc1_in.valid = lsu_p.valid   & ~flush_dc2_up[lsu_p.tid];
      pkt_dc2_in.valid = pkt_dc1.valid & ~flush_dc2_up[pkt_dc1.tid];
      pkt_dc3_in.valid = pkt_dc2.valid & ~flush_dc2_up[pkt_dc2.tid];
      pkt_dc4_in.valid = pkt_dc3.valid & ~flush_dc3[pkt_dc3.tid];
      pkt_dc5_in.valid = pkt_dc4.valid & ~flush_dc4[pkt_dc4.tid];
   end

   // ******************************
   // Packet stages
   // ******************************
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pkt_dc1.valid <= 1'b0;
         pkt_dc2.valid <= 1'b0;
         pkt_dc3.valid <= 1'b0;
         pkt_dc4.valid <= 1'b0;
         pkt_dc5.valid <= 1'b0;
      end else begin
         pkt_dc1 <= pkt_dc1_in;
         pkt_dc2 <= pkt_dc2_in;
         pkt_dc3 <= pkt_dc3_in;
         pkt_dc4 <= pkt_dc4_in;
         pkt_dc5 <= pkt_dc5_in;
      end
   end

   // Operands, address and store data
   always_ff @(posedge clk) begin
      rs1_dc1        <= rs1_d;
      offset_dc1     <= offset_d;
      store_data_dc1 <= rs2_d;

      addr_dc2       <= addr_dc1;
      region_dc2     <= region_dc1;
      misaligned_dc2 <= misaligned_dc1;
      store_data_dc2 <= store_data_dc1;

      addr_dc3       <= addr_dc2;
      region_dc3     <= region_dc2;
      misaligned_dc3 <= misaligned_dc2;
      store_data_dc3 <= store_data_dc2;

      addr_dc4       <= addr_dc3;   // Address only beyond DC3
      addr_dc5       <= addr_dc4;
   end

   // A packet reaching DC3 must have come through decode with a known op
   a_dc3_op_known: assert property (@(posedge clk) disable iff (!rst_n)
      pkt_dc3.valid |-> !$isunknown(pkt_dc3.op));

endmodule

`default_nettype wire

// ==== verilog/lsu_load_align.sv ====
// DC3 load data path and exception record.
// Picks read data from the region of the access, extends it to the access
// size and flags misaligned packets, all in the DC3 cycle.

`timescale 1ns/100ps
`default_nettype none

`include "lsu_ctl_config.svh"

module lsu_load_align (
   input  lsu_ctl_pkg::lsu_pkt_t         pkt_dc3,
   input  logic [31:0]                   addr_dc3,
   input  lsu_ctl_pkg::lsu_region_e      region_dc3,
   input  logic                          misaligned_dc3,
   input  logic [`LSU_NUM_THREADS-1:0]   flush_dc3,
   input  logic [31:0]                   dccm_rd_data_dc3,
   input  logic [31:0]                   pic_rd_data_dc3,
   input  logic [31:0]                   bus_rd_data_dc3,
   output logic [31:0]                   lsu_result_dc3,
   output logic                          exc_valid_dc3,
   output logic [31:0]                   exc_addr_dc3
);

   import lsu_ctl_pkg::*;

   logic [31:0]  ld_data_dc3;
   logic         is_load_dc3;

   // Region select
   always_comb begin
      case (region_dc3)
         RG_DCCM: ld_data_dc3 = dccm_rd_data_dc3;
         RG_PIC:  ld_data_dc3 = pic_rd_data_dc3;
         default: ld_data_dc3 = bus_rd_data_dc3;
      endcase
   end

   assign is_load_dc3 = pkt_dc3.valid & ((pkt_dc3.op == OP_LOAD) | (pkt_dc3.op == OP_LR));

   // Size and sign extension, zero when not a load
   always_comb begin
      lsu_result_dc3 = '0;
      if (is_load_dc3) begin
         case (pkt_dc3.size)
            SZ_BYTE: lsu_result_dc3 = pkt_dc3.unsign ? {24'b0, ld_data_dc3[7:0]} :
                                      {{24{ld_data_dc3[7]}}, ld_data_dc3[7:0]};
            SZ_HALF: lsu_result_dc3 = pkt_dc3.unsign ? {16'b0, ld_data_dc3[15:0]} :
                                      {{16{ld_data_dc3[15]}}, ld_data_dc3[15:0]};
            default: lsu_result_dc3 = ld_data_dc3;   // Full word
         endcase
      end
   end

   // Exception record for a surviving misaligned access
   assign exc_valid_dc3 = pkt_dc3.valid & misaligned_dc3 & ~flush_dc3[pkt_dc3.tid];
   assign exc_addr_dc3  = addr_dc3 & {32{exc_valid_dc3}};

endmodule

`default_nettype wire

// ==== verilog/lsu_reservation.sv ====
// Load reservation stations and DC5 commit for the LSU.
// One station per thread holds the word address of the last committed LR.
// SC success is decided in DC5; station updates land on the next edge.

`timescale 1ns/100ps
`default_nettype none

`include "lsu_ctl_config.svh"

module lsu_reservation (
   input  logic                          clk,
   input  logic                          rst_n,
   input  lsu_ctl_pkg::lsu_pkt_t         pkt_dc5,
   input  logic [31:0]                   addr_dc5,
   input  logic [`LSU_NUM_THREADS-1:0]   flush_dc5,
   input  logic [`LSU_NUM_THREADS-1:0]   lr_reset,   // Clear request per thread
   output logic                          lsu_commit_dc5,
   output logic                          lsu_sc_success_dc5,
   output logic [`LSU_NUM_THREADS-1:0]   lr_vld
);

   import lsu_ctl_pkg::*;

   logic [`LSU_NUM_THREADS-1:0][31:2]  lr_addr;   // Reserved word per thread
   logic [`LSU_NUM_THREADS-1:0]        lr_set;
   logic [`LSU_NUM_THREADS-1:0]        lr_clr;
   logic                               is_sc_dc5;
   logic                               wr_dc5;    // Store or successful SC

   // ******************************
   // Commit and SC decision
   // ******************************
   assign lsu_commit_dc5 = pkt_dc5.valid & ~flush_dc5[pkt_dc5.tid];

   assign is_sc_dc5 = (pkt_dc5.op == OP_SC);

   assign lsu_sc_success_dc5 = pkt_dc5.valid & is_sc_dc5 & lr_vld[pkt_dc5.tid] &
                               (addr_dc5[31:2] == lr_addr[pkt_dc5.tid]);

   assign wr_dc5 = (pkt_dc5.op == OP_STORE) | (is_sc_dc5 & lsu_sc_success_dc5);

   // ******************************
   // Station set and clear
   // ******************************
   always_comb begin
      for (int i = 0; i < `LSU_NUM_THREADS; i++) begin
         if (lsu_tid_t'(i) == pkt_dc5.tid) begin
            lr_set[i] = lsu_commit_dc5 & (pkt_dc5.op == OP_LR);
            lr_clr[i] = (lsu_commit_dc5 & is_sc_dc5) | lr_reset[i];   // Any own SC
         end else begin
            // Another thread wrote the reserved word
            lr_set[i] = 1'b0;
            lr_clr[i] = (lsu_commit_dc5 & wr_dc5 & (addr_dc5[31:2] == lr_addr[i])) |
                        lr_reset[i];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         lr_vld <= '0;
      end else begin
         for (int i = 0; i < `LSU_NUM_THREADS; i++) begin
            if (lr_clr[i]) begin
               lr_vld[i] <= 1'b0;   // Clear beats set
            end else if (lr_set[i]) begin
               lr_vld[i] <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < `LSU_NUM_THREADS; i++) begin
         if (lr_set[i]) begin
            lr_addr[i] <= addr_dc5[31:2];
         end
      end
   end

   // SC success only ever reported for an SC in DC5
   a_sc_only: assert property (@(posedge clk) disable iff (!rst_n)
      lsu_sc_success_dc5 |-> (pkt_dc5.op == OP_SC));

endmodule

`default_nettype wire

// ==== verilog/lsu_ctl_top.sv ====
// Top level of the LSU control pipeline.
// Connects the stage registers, DC1 address generation, DC3 load alignment
// and the DC5 reservation stations.

`timescale 1ns/100ps
`default_nettype none

`include "lsu_ctl_config.svh"

module lsu_ctl_top (
   input  logic                          clk,
   input  logic                          rst_n,

   input  lsu_ctl_pkg::lsu_pkt_t         lsu_p,
   input  logic [31:0]                   rs1_d,
   input  logic [11:0]                   offset_d,
   input  logic [31:0]                   rs2_d,

   input  logic [`LSU_NUM_THREADS-1:0]   flush_dc2_up,
   input  logic [`LSU_NUM_THREADS-1:0]   flush_dc3,
   input  logic [`LSU_NUM_THREADS-1:0]   flush_dc4,
   input  logic [`LSU_NUM_THREADS-1:0]   flush_dc5,
   input  logic [`LSU_NUM_THREADS-1:0]   lr_reset,

   input  logic [31:0]                   dccm_rd_data_dc3,
   input  logic [31:0]                   pic_rd_data_dc3,
   input  logic [31:0]                   bus_rd_data_dc3,

   output logic [31:0]                   lsu_addr_dc3,
   output lsu_ctl_pkg::lsu_region_e      region_dc3,
   output logic [31:0]                   store_data_dc3,
   output logic [31:0]                   lsu_result_dc3,
   output logic                          exc_valid_dc3,
   output logic [31:0]                   exc_addr_dc3,
   output logic                          lsu_commit_dc5,
   output logic                          lsu_sc_success_dc5,
   output logic [`LSU_NUM_THREADS-1:0]   lr_vld
);

   // DC1 loop between the stage registers and the adder
   logic [31:0]               rs1_dc1;
   logic [11:0]               offset_dc1;
   lsu_ctl_pkg::lsu_pkt_t     pkt_dc1;
   logic [31:0]               addr_dc1;
   lsu_ctl_pkg::lsu_region_e  region_dc1;
   logic                      misaligned_dc1;

   lsu_ctl_pkg::lsu_pkt_t     pkt_dc3;
   logic                      misaligned_dc3;
   lsu_ctl_pkg::lsu_pkt_t     pkt_dc5;
   logic [31:0]               addr_dc5;

   lsu_pkt_pipe lsu_pkt_pipe_inst (
      .clk, .rst_n, .lsu_p, .rs1_d, .offset_d, .rs2_d,
      .flush_dc2_up, .flush_dc3, .flush_dc4,
      .addr_dc1, .region_dc1, .misaligned_dc1,
      .rs1_dc1, .offset_dc1, .pkt_dc1,
      .pkt_dc3, .addr_dc3(lsu_addr_dc3), .region_dc3, .misaligned_dc3, .store_data_dc3,
      .pkt_dc5, .addr_dc5
   );

   lsu_addr_gen lsu_addr_gen_inst (
      .rs1_dc1, .offset_dc1, .size_dc1(pkt_dc1.size),
      .addr_dc1, .region_dc1, .misaligned_dc1
   );

   lsu_load_align lsu_load_align_inst (
      .pkt_dc3, .addr_dc3(lsu_addr_dc3), .region_dc3, .misaligned_dc3, .flush_dc3,
      .dccm_rd_data_dc3, .pic_rd_data_dc3, .bus_rd_data_dc3,
      .lsu_result_dc3, .exc_valid_dc3, .exc_addr_dc3
   );

   lsu_reservation lsu_reservation_inst (
      .clk, .rst_n, .pkt_dc5, .addr_dc5, .flush_dc5, .lr_reset,
      .lsu_commit_dc5, .lsu_sc_success_dc5, .lr_vld
   );

endmodule

`default_nettype wire

// ==== verification/lsu_ctl_tb.sv ====
// Self-checking testbench for the LSU control pipeline.
// Issues one table row at a time, then checks the DC3 and DC5 outputs
// against values worked out from the address, region and LR/SC rules.

`timescale 1ns/100ps
`default_nettype none

`include "lsu_ctl_config.svh"

module lsu_ctl_tb;

   import lsu_ctl_pkg::*;

   localparam int CLK_PERIOD = 8;
   localparam int NT         = `LSU_NUM_THREADS;

   typedef struct packed {
      logic          valid;
      lsu_op_e       op;
      lsu_size_e     size;
      logic          unsign;
      lsu_tid_t      tid;
      logic [31:0]   rs1;
      logic [11:0]   offset;
      int            fl_stage;     // 0 for none, else 2 to 5
      lsu_tid_t      fl_tid;
      logic [NT-1:0] lr_rst;       // Raised in the DC5 cycle
      lsu_region_e   exp_region;
      logic          exp_exc;
      logic          exp_commit;
      logic          exp_sc;
      logic [NT-1:0] exp_lr_vld;   // Seen one edge after DC5
   } row_t;

   logic             clk;
   logic             rst_n;
   lsu_pkt_t         lsu_p;
   logic [31:0]      rs1_d;
   logic [11:0]      offset_d;
   logic [31:0]      rs2_d;
   logic [NT-1:0]    flush_dc2_up;
   logic [NT-1:0]    flush_dc3;
   logic [NT-1:0]    flush_dc4;
   logic [NT-1:0]    flush_dc5;
   logic [NT-1:0]    lr_reset;
   logic [31:0]      dccm_rd_data_dc3;
   logic [31:0]      pic_rd_data_dc3;
   logic [31:0]      bus_rd_data_dc3;
   logic [31:0]      lsu_addr_dc3;
   lsu_region_e      region_dc3;
   logic [31:0]      store_data_dc3;
   logic [31:0]      lsu_result_dc3;
   logic             exc_valid_dc3;
   logic [31:0]      exc_addr_dc3;
   logic             lsu_commit_dc5;
   logic             lsu_sc_success_dc5;
   logic [NT-1:0]    lr_vld;

   row_t             rows[$];
   int               cur_row;
   logic [31:0]      lcg_state;

   lsu_ctl_top lsu_ctl_top_inst (
      .clk, .rst_n, .lsu_p, .rs1_d, .offset_d, .rs2_d,
      .flush_dc2_up, .flush_dc3, .flush_dc4, .flush_dc5, .lr_reset,
      .dccm_rd_data_dc3, .pic_rd_data_dc3, .bus_rd_data_dc3,
      .lsu_addr_dc3, .region_dc3, .store_data_dc3, .lsu_result_dc3,
      .exc_valid_dc3, .exc_addr_dc3, .lsu_commit_dc5, .lsu_sc_success_dc5, .lr_vld
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // ******************************
   // Helpers
   // ******************************
   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic [NT-1:0] thread_mask(input lsu_tid_t t);
      logic [NT-1:0] m;
      m    = '0;
      m[t] = 1'b1;
      return m;
   endfunction

   function automatic lsu_pkt_t idle_pkt();
      lsu_pkt_t p;
      p.valid  = 1'b0;
      p.tid    = '0;
      p.op     = OP_LOAD;
      p.size   = SZ_WORD;
      p.unsign = 1'b0;
      return p;
   endfunction

   function automatic logic [31:0] effective_addr(input logic [31:0] base,
                                                  input logic [11:0] off);
      return base + {{20{off[11]}}, off};
   endfunction

   // Load data as the core should see it in DC3
   function automatic logic [31:0] expected_load(input row_t r, input logic [31:0] dccm,
                                                 input logic [31:0] pic, input logic [31:0] bus);
      logic [31:0] d;
      logic        live;
      logic [31:0] res;
      live = r.valid && !(r.fl_stage == 2 && r.fl_tid == r.tid);   // Killed before DC3
      case (r.exp_region)
         RG_DCCM: d = dccm;
         RG_PIC:  d = pic;
         default: d = bus;
      endcase
      case (r.size)
         SZ_BYTE: res = r.unsign ? {24'h0, d[7:0]} : {{24{d[7]}}, d[7:0]};
         SZ_HALF: res = r.unsign ? {16'h0, d[15:0]} : {{16{d[15]}}, d[15:0]};
         default: res = d;
      endcase
      if (!live || !(r.op == OP_LOAD || r.op == OP_LR)) begin
         res = 32'h0;
      end
      return res;
   endfunction

   task automatic stop_on_error(input string reason);
      $display("%s", reason);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         stop_on_error($sformatf("FAIL at %0t ns: row %0d %s is %h, expected %h",
                                 $time, cur_row, what, got, exp));
      end
   endtask

   task automatic check_region(input string what, input lsu_region_e got,
                               input lsu_region_e exp);
      if (got !== exp) begin
         stop_on_error($sformatf("FAIL at %0t ns: row %0d %s is %s, expected %s",
                                 $time, cur_row, what, got.name(), exp.name()));
      end
   endtask

   task automatic check_flag(input string what, input logic got, input logic exp);
      if (got !== exp) begin
         stop_on_error($sformatf("FAIL at %0t ns: row %0d %s is %b, expected %b",
                                 $time, cur_row, what, got, exp));
      end
   endtask

   // Counted clock edges, with a guard on elapsed time
   task automatic wait_clk(input int n, input bit falling);
      int  cnt;
      time t0;
      cnt = 0;
      t0  = $time;
      while (cnt < n) begin
         if (falling) begin
            @(negedge clk);
         end else begin
            @(posedge clk);
         end
         cnt++;
         if ($time - t0 > (n + 1) * CLK_PERIOD) begin
            stop_on_error("Timeout: the clock did not reach the expected edge in time");
         end
      end
   endtask

   task automatic add_row(input logic v, input lsu_op_e op, input lsu_size_e sz,
                          input logic u, input lsu_tid_t tid, input logic [31:0] rs1,
                          input logic [11:0] off, input int fl_stage, input lsu_tid_t fl_tid,
                          input logic [NT-1:0] lr_rst, input lsu_region_e rg,
                          input logic exc, input logic cmt, input logic sc,
                          input logic [NT-1:0] lrv);
      row_t r;
      r.valid      = v;
      r.op         = op;
      r.size       = sz;
      r.unsign     = u;
      r.tid        = tid;
      r.rs1        = rs1;
      r.offset     = off;
      r.fl_stage   = fl_stage;
      r.fl_tid     = fl_tid;
      r.lr_rst     = lr_rst;
      r.exp_region = rg;
      r.exp_exc    = exc;
      r.exp_commit = cmt;
      r.exp_sc     = sc;
      r.exp_lr_vld = lrv;
      rows.push_back(r);
   endtask

   // ******************************
   // Stimulus table
   // ******************************
   // valid op size unsign tid rs1 offset flush_stage flush_tid lr_reset
   //   then region exc commit sc lr_vld
   task automatic build_table();
      // Address, region and load extension
      add_row(1'b1, OP_LOAD, SZ_WORD, 1'b0, 1'b0, 32'hF004_0100, 12'h010, 0, 1'b0, 2'b00,
              RG_DCCM, 1'b0, 1'b1, 1'b0, 2'b00);
      add_row(1'b1, OP_LOAD, SZ_BYTE, 1'b0, 1'b0, 32'hF00C_0020, 12'hFFF, 0, 1'b0, 2'b00,
              RG_PIC, 1'b0, 1'b1, 1'b0, 2'b00);
      add_row(1'b1, OP_LOAD, SZ_BYTE, 1'b1, 1'b1, 32'h0000_2000, 12'h003, 0, 1'b0, 2'b00,
              RG_EXT, 1'b0, 1'b1, 1'b0, 2'b00);
      add_row(1'b1, OP_LOAD, SZ_HALF, 1'b0, 1'b1, 32'hF004_0000, 12'h802, 0, 1'b0, 2'b00,
              RG_EXT, 1'b0, 1'b1, 1'b0, 2'b00);   // Negative offset leaves the DCCM
      add_row(1'b1, OP_LOAD, SZ_HALF, 1'b1, 1'b0, 32'hF00C_1000, 12'hF00, 0, 1'b0, 2'b00,
              RG_PIC, 1'b0, 1'b1, 1'b0, 2'b00);
      add_row(1'b1, OP_LOAD, SZ_WORD, 1'b1, 1'b1, 32'hF004_8000, 12'h7FC, 0, 1'b0, 2'b00,
              RG_DCCM, 1'b0, 1'b1, 1'b0, 2'b00);
      add_row(1'b1, OP_STORE, SZ_WORD, 1'b0, 1'b0, 32'h0001_0000, 12'h004, 0, 1'b0, 2'b00,
              RG_EXT, 1'b0, 1'b1, 1'b0, 2'b00);
      // Misaligned accesses
      add_row(1'b1, OP_LOAD, SZ_HALF, 1'b0, 1'b0, 32'hF004_0000, 12'h001, 0, 1'b0, 2'b00,
              RG_DCCM, 1'b1, 1'b1, 1'b0, 2'b00);
      add_row(1'b1, OP_LOAD, SZ_WORD, 1'b0, 1'b1, 32'hF00C_0000, 12'h006, 0, 1'b0, 2'b00,
              RG_PIC, 1'b1, 1'b1, 1'b0, 2'b00);
      // Flushes, own thread then other thread
      add_row(1'b1, OP_LOAD, SZ_WORD, 1'b0, 1'b0, 32'hF004_0200, 12'h000, 2, 1'b0, 2'b00,
              RG_DCCM, 1'b0, 1'b0, 1'b0, 2'b00);
      add_row(1'b1, OP_LOAD, SZ_WORD, 1'b0, 1'b1, 32'hF004_0200, 12'h002, 3, 1'b1, 2'b00,
              RG_DCCM, 1'b0, 1'b0, 1'b0, 2'b00);
      add_row(1'b1, OP_STORE, SZ_WORD, 1'b0, 1'b0, 32'h0000_3000, 12'h000, 4, 1'b0, 2'b00,
              RG_EXT, 1'b0, 1'b0, 1'b0, 2'b00);
      add_row(1'b1, OP_LOAD, SZ_WORD, 1'b0, 1'b1, 32'h0000_3000, 12'h008, 5, 1'b1, 2'b00,
              RG_EXT, 1'b0, 1'b0, 1'b0, 2'b00);
      add_row(1'b1, OP_LOAD, SZ_HALF, 1'b0, 1'b0, 32'hF004_0000, 12'h003, 3, 1'b1, 2'b00,
              RG_DCCM, 1'b1, 1'b1, 1'b0, 2'b00);
      add_row(1'b1, OP_STORE, SZ_WORD, 1'b0, 1'b1, 32'h0000_3000, 12'h010, 5, 1'b0, 2'b00,
              RG_EXT, 1'b0, 1'b1, 1'b0, 2'b00);
      add_row(1'b1, OP_LOAD, SZ_WORD, 1'b0, 1'b1, 32'h0000_3000, 12'h014, 2, 1'b0, 2'b00,
              RG_EXT, 1'b0, 1'b1, 1'b0, 2'b00);
      // LR/SC sequences
      add_row(1'b1, OP_LR, SZ_WORD, 1'b0, 1'b0, 32'hF004_0000, 12'h040, 0, 1'b0, 2'b00,
              RG_DCCM, 1'b0, 1'b1, 1'b0, 2'b01);
      add_row(1'b1, OP_SC, SZ_WORD, 1'b0, 1'b0, 32'hF004_0000, 12'h040, 0, 1'b0, 2'b00,
              RG_DCCM, 1'b0, 1'b1, 1'b1, 2'b00);
      add_row(1'b1, OP_SC, SZ_WORD, 1'b0, 1'b0, 32'hF004_0000, 12'h040, 0, 1'b0, 2'b00,
              RG_DCCM, 1'b0, 1'b1, 1'b0, 2'b00);   // No reservation left
      add_row(1'b1, OP_LR, SZ_WORD, 1'b0, 1'b1, 32'hF004_0000, 12'h080, 0, 1'b0, 2'b00,
              RG_DCCM, 1'b0, 1'b1, 1'b0, 2'b10);
      add_row(1'b1, OP_STORE, SZ_HALF, 1'b0, 1'b0, 32'hF004_0000, 12'h082, 0, 1'b0, 2'b00,
              RG_DCCM, 1'b0, 1'b1, 1'b0, 2'b00);   // Other thread hits the reserved word
      add_row(1'b1, OP_LR, SZ_WORD, 1'b0, 1'b0, 32'h0000_4000, 12'h000, 0, 1'b0, 2'b00,
              RG_EXT, 1'b0, 1'b1, 1'b0, 2'b01);
      add_row(1'b1, OP_LR, SZ_WORD, 1'b0, 1'b1, 32'h0000_5000, 12'h000, 0, 1'b0, 2'b00,
              RG_EXT, 1'b0, 1'b1, 1'b0, 2'b11);
      add_row(1'b0, OP_LOAD, SZ_WORD, 1'b0, 1'b0, 32'h0000_0000, 12'h000, 0, 1'b0, 2'b01,
              RG_EXT, 1'b0, 1'b0, 1'b0, 2'b10);
      add_row(1'b1, OP_SC, SZ_WORD, 1'b0, 1'b1, 32'h0000_5000, 12'h000, 0, 1'b0, 2'b00,
              RG_EXT, 1'b0, 1'b1, 1'b1, 2'b00);
      add_row(1'b1, OP_LR, SZ_WORD, 1'b0, 1'b0, 32'h0000_4000, 12'h000, 5, 1'b0, 2'b00,
              RG_EXT, 1'b0, 1'b0, 1'b0, 2'b00);
   endtask

   // ******************************
   // Row sequencing
   // ******************************
   task automatic run_row(input row_t r);
      lsu_pkt_t    pkt;
      logic [31:0] addr_exp;
      logic [31:0] d_dccm;
      logic [31:0] d_pic;
      logic [31:0] d_bus;
      logic [31:0] d_rs2;
      pkt.valid  = r.valid;
      pkt.tid    = r.tid;
      pkt.op     = r.op;
      pkt.size   = r.size;
      pkt.unsign = r.unsign;
      addr_exp   = effective_addr(r.rs1, r.offset);
      lcg_state  = lcg_next(lcg_state);
      d_dccm     = lcg_state;
      lcg_state  = lcg_next(lcg_state);
      d_pic      = lcg_state;
      lcg_state  = lcg_next(lcg_state);
      d_bus      = lcg_state;
      lcg_state  = lcg_next(lcg_state);
      d_rs2      = lcg_state;

      wait_clk(1, 1'b0);                 // Decode cycle starts
      lsu_p            <= pkt;
      rs1_d            <= r.rs1;
      offset_d         <= r.offset;
      rs2_d            <= d_rs2;
      dccm_rd_data_dc3 <= d_dccm;
      pic_rd_data_dc3  <= d_pic;
      bus_rd_data_dc3  <= d_bus;
      wait_clk(1, 1'b0);                 // Captured into DC1
      lsu_p <= idle_pkt();

      for (int k = 1; k <= 5; k++) begin
         wait_clk(1, 1'b0);
         flush_dc2_up <= '0;
         flush_dc3    <= '0;
         flush_dc4    <= '0;
         flush_dc5    <= '0;
         lr_reset     <= '0;
         if (r.fl_stage == k + 1) begin
            case (r.fl_stage)
               2:       flush_dc2_up <= thread_mask(r.fl_tid);
               3:       flush_dc3    <= thread_mask(r.fl_tid);
               4:       flush_dc4    <= thread_mask(r.fl_tid);
               default: flush_dc5    <= thread_mask(r.fl_tid);
            endcase
         end
         if (k == 4) begin
            lr_reset <= r.lr_rst;
         end

         if (k == 2) begin                // Packet sits in DC3
            wait_clk(1, 1'b1);
            check_word("DC3 address", lsu_addr_dc3, addr_exp);
            check_region("DC3 region", region_dc3, r.exp_region);
            check_word("store data", store_data_dc3, d_rs2);
            check_word("load result", lsu_result_dc3, expected_load(r, d_dccm, d_pic, d_bus));
            check_flag("exception valid", exc_valid_dc3, r.exp_exc);
            check_word("exception address", exc_addr_dc3, r.exp_exc ? addr_exp : 32'h0);
         end else if (k == 4) begin       // Packet sits in DC5
            wait_clk(1, 1'b1);
            check_flag("commit", lsu_commit_dc5, r.exp_commit);
            check_flag("SC success", lsu_sc_success_dc5, r.exp_sc);
         end else if (k == 5) begin
            wait_clk(1, 1'b1);
            for (int t = 0; t < NT; t++) begin
               check_flag($sformatf("lr_vld[%0d]", t), lr_vld[t], r.exp_lr_vld[t]);
            end
         end
      end
   endtask

   initial begin
      rst_n            <= 1'b0;
      lsu_p            <= idle_pkt();
      rs1_d            <= '0;
      offset_d         <= '0;
      rs2_d            <= '0;
      flush_dc2_up     <= '0;
      flush_dc3        <= '0;
      flush_dc4        <= '0;
      flush_dc5        <= '0;
      lr_reset         <= '0;
      dccm_rd_data_dc3 <= '0;
      pic_rd_data_dc3  <= '0;
      bus_rd_data_dc3  <= '0;
      cur_row          = 0;
      lcg_state        = 32'h7f974375;
      build_table();

      wait_clk(8, 1'b0);                 // Reset held for 8 cycles
      rst_n <= 1'b1;

      foreach (rows[i]) begin
         cur_row = i;
         run_row(rows[i]);
      end

      $display("All %0d rows checked", rows.size());
      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+verilog
verilog/lsu_ctl_pkg.sv
verilog/lsu_addr_gen.sv
verilog/lsu_pkt_pipe.sv
verilog/lsu_load_align.sv
verilog/lsu_reservation.sv
verilog/lsu_ctl_top.sv
verification/lsu_ctl_tb.sv

// ==== Makefile ====
# Verilator flow for the LSU control pipeline

VERILATOR  ?= verilator
TOP        := lsu_ctl_tb
FILELIST   := build.f
OBJ_DIR    := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0

PASS_STRING := TEST RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_STRING)" $(LOG) || (echo "Simulation did not pass"; exit 1)
	@echo "Simulation log shows a pass"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
